/* rtl/bp_isa_pkg.sv */
// instruction set constants that the fetch-stage predictor needs to decode
package bp_isa_pkg;

    // width of every PC and branch target in the pipeline
    localparam int XLEN = 32;

    // the major opcode sits in instruction bits [6:0]
    localparam int OPCODE_W = 7;

    // conditional branches (beq, bne, blt, bge, bltu, bgeu)
    localparam logic [OPCODE_W-1:0] OPCODE_BRANCH = 7'b1100011;

    // direct jump with a pc-relative target
    localparam logic [OPCODE_W-1:0] OPCODE_JAL = 7'b1101111;

    // register-indirect jump that is predicted from the last seen target
    localparam logic [OPCODE_W-1:0] OPCODE_JALR = 7'b1100111;

endpackage

/* rtl/bp_config_pkg.sv */
// predictor configuration with the counter encoding and the control register map
package bp_config_pkg;

    // every pattern history entry is a 2-bit saturating counter
    localparam int CNT_W = 2;

    // the upper half of the range predicts taken, so the msb alone gives the direction
    localparam logic [CNT_W-1:0] CNT_STRONG_NT = 2'b00;
    localparam logic [CNT_W-1:0] CNT_WEAK_NT   = 2'b01;
    localparam logic [CNT_W-1:0] CNT_WEAK_T    = 2'b10;
    localparam logic [CNT_W-1:0] CNT_STRONG_T  = 2'b11;

    // there are two registers, so a single address bit selects between them
    localparam int CFG_ADDR_W = 1;

    // the control register holds the two enable bits and both are set after reset
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL = 1'b0;
    localparam int CTRL_DYNAMIC_BIT  = 0;
    localparam int CTRL_BACKWARD_BIT = 1;

    // writing a 1 to the clear bit of the history register zeroes the GHR
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_HIST = 1'b1;
    localparam int HIST_CLEAR_BIT = 0;

endpackage

/* rtl/branch_target_buffer.sv */
`timescale 1ns/100ps

// direct-mapped branch target buffer
// the lookup is purely combinational so the fetch stage gets its answer in the
// same cycle, while writes from execute land at the next rising edge
module branch_target_buffer
    import bp_isa_pkg::*;
#(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            btb_we_i,
    input  logic [XLEN-1:0] upd_pc_i,
    input  logic [XLEN-1:0] upd_target_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o
);

    // instructions are word aligned, so pc bits [1:0] never take part in the index
    localparam int IDX_W = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;

    // target and tag storage with one word per entry
    logic [XLEN-1:0]  target_q [NUM_BTB_ENTRIES];
    logic [TAG_W-1:0] tag_q    [NUM_BTB_ENTRIES];

    // one valid bit per entry
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    // lookup index and tag split from the fetch pc
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;

    // write index and tag split from the pc of the resolved branch
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[XLEN-1:IDX_W+2];
    assign wr_idx = upd_pc_i[IDX_W+1:2];
    assign wr_tag = upd_pc_i[XLEN-1:IDX_W+2];

    // a hit needs a valid entry whose stored tag matches the upper pc bits
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // the target is passed on even on a miss and the top level ignores it then
    assign target_o = target_q[rd_idx];

    // all entries are invalid after reset and each write sets one valid bit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (btb_we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // an entry of the payload arrays is overwritten whenever its index is written again
    always_ff @(posedge clk) begin
        if (btb_we_i) begin
            target_q[wr_idx] <= upd_target_i;
            tag_q[wr_idx]    <= wr_tag;
        end
    end

    // the execute stage must deliver a resolved target along with the strobe,
    // otherwise an X would be fetched from later as a valid prediction
    a_target_known : assert property (
        @(posedge clk) disable iff (reset_i)
        btb_we_i |-> !$isunknown(upd_target_i)
    ) else $error("btb write with unknown target");

endmodule

/* rtl/gshare_predictor.sv */
`timescale 1ns/100ps

// gshare direction predictor
// the global history register is xored with the word-aligned pc to index a
// table of saturating counters, and the execute stage trains the table with
// the index that was carried down the pipeline with the branch
module gshare_predictor
    import bp_isa_pkg::*;
    import bp_config_pkg::*;
#(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [XLEN-1:0]         pc_i,
    input  logic                    pht_we_i,
    input  logic [NUM_GHR_BITS-1:0] pht_windex_i,
    input  logic                    pht_taken_i,
    input  logic                    ghr_clear_i,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    pht_taken_o
);

    // one counter per history pattern
    localparam int PHT_SIZE = 1 << NUM_GHR_BITS;

    // history register whose lsb holds the most recent outcome
    logic [NUM_GHR_BITS-1:0] ghr_q;

    // pattern history table
    logic [CNT_W-1:0] pht_q [PHT_SIZE];

    // read index is the history hashed with the low pc bits above the byte offset
    assign pht_index_o = ghr_q ^ pc_i[NUM_GHR_BITS+1:2];

    // the two taken states are exactly those at or above weakly taken, i.e. the msb
    assign pht_taken_o = (pht_q[pht_index_o] >= CNT_WEAK_T);

    // history shift
    // a clear from the control block wins over an outcome arriving at the same edge
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (pht_we_i) begin
            ghr_q <= {ghr_q[NUM_GHR_BITS-2:0], pht_taken_i};
        end
    end

    // counter training
    // taken moves one step up and not taken one step down, and both ends hold
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht_q[i] <= CNT_WEAK_NT;
            end
        end else if (pht_we_i) begin
            if (pht_taken_i) begin
                if (pht_q[pht_windex_i] != CNT_STRONG_T) begin
                    pht_q[pht_windex_i] <= pht_q[pht_windex_i] + 1'b1;
                end
            end else begin
                if (pht_q[pht_windex_i] != CNT_STRONG_NT) begin
                    pht_q[pht_windex_i] <= pht_q[pht_windex_i] - 1'b1;
                end
            end
        end
    end

    // a taken training of a strongly taken counter must not wrap around to 00,
    // checked on the entry that was addressed in the previous cycle
    a_sat_high : assert property (
        @(posedge clk) disable iff (reset_i)
        (pht_we_i && pht_taken_i && (pht_q[pht_windex_i] == CNT_STRONG_T))
        |=> (pht_q[$past(pht_windex_i)] == CNT_STRONG_T)
    ) else $error("pht counter wrapped past strongly taken");

endmodule

/* rtl/predictor_control_regs.sv */
`timescale 1ns/100ps

// software-visible control of the predictor
// address 0 holds the two enable bits, address 1 is a write-only command
// register whose clear bit produces a single-cycle pulse towards the GHR
module predictor_control_regs
    import bp_isa_pkg::*;
    import bp_config_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cfg_we_i,
    input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [XLEN-1:0]       cfg_wdata_i,
    output logic [XLEN-1:0]       cfg_rdata_o,
    output logic                  dynamic_en_o,
    output logic                  backward_en_o,
    output logic                  ghr_clear_o
);

    // decoded write strobes for the two registers
    logic ctrl_we;
    logic clear_req;

    assign ctrl_we   = cfg_we_i && (cfg_addr_i == CFG_ADDR_CTRL);
    assign clear_req = cfg_we_i && (cfg_addr_i == CFG_ADDR_HIST) && cfg_wdata_i[HIST_CLEAR_BIT];

    // both enable bits are on out of reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dynamic_en_o  <= 1'b1;
            backward_en_o <= 1'b1;
        end else if (ctrl_we) begin
            dynamic_en_o  <= cfg_wdata_i[CTRL_DYNAMIC_BIT];
            backward_en_o <= cfg_wdata_i[CTRL_BACKWARD_BIT];
        end
    end

    // the clear pulse is registered, so the GHR is zero two edges after the write
    // a second request while the pulse is high merges into the running clear
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_clear_o <= 1'b0;
        end else begin
            ghr_clear_o <= clear_req && !ghr_clear_o;
        end
    end

    // the control register is always visible and the unused upper bits read zero
    always_comb begin
        cfg_rdata_o                    = '0;
        cfg_rdata_o[CTRL_DYNAMIC_BIT]  = dynamic_en_o;
        cfg_rdata_o[CTRL_BACKWARD_BIT] = backward_en_o;
    end

    // the gshare block relies on a clean one-cycle pulse per clear command
    a_clear_pulse : assert property (
        @(posedge clk) disable iff (reset_i)
        ghr_clear_o |=> !ghr_clear_o
    ) else $error("ghr clear held for more than one cycle");

endmodule

/* rtl/branch_predictor.sv */
`timescale 1ns/100ps

// fetch-stage branch prediction unit
// joins the target buffer, the gshare direction predictor and the control
// registers, and picks the next fetch pc in the same cycle as the lookup
module branch_predictor
    import bp_isa_pkg::*;
    import bp_config_pkg::*;
#(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [XLEN-1:0]         pc_i,
    input  logic [OPCODE_W-1:0]     op_i,
    input  logic                    btb_we_i,
    input  logic [XLEN-1:0]         upd_pc_i,
    input  logic [XLEN-1:0]         upd_target_i,
    input  logic                    pht_we_i,
    input  logic [NUM_GHR_BITS-1:0] pht_windex_i,
    input  logic                    pht_taken_i,
    input  logic                    cfg_we_i,
    input  logic [CFG_ADDR_W-1:0]   cfg_addr_i,
    input  logic [XLEN-1:0]         cfg_wdata_i,
    output logic [XLEN-1:0]         next_pc_o,
    output logic                    taken_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic [XLEN-1:0]         cfg_rdata_o
);

    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            pht_taken;
    logic            dynamic_en;
    logic            backward_en;
    logic            ghr_clear;
    logic            is_branch;
    logic            is_jump;
    logic            is_backward;

    branch_target_buffer #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)
    ) u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .btb_we_i    (btb_we_i),
        .upd_pc_i    (upd_pc_i),
        .upd_target_i(upd_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    gshare_predictor #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) u_gshare (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .pht_we_i    (pht_we_i),
        .pht_windex_i(pht_windex_i),
        .pht_taken_i (pht_taken_i),
        .ghr_clear_i (ghr_clear),
        .pht_index_o (pht_index_o),
        .pht_taken_o (pht_taken)
    );

    predictor_control_regs u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .dynamic_en_o (dynamic_en),
        .backward_en_o(backward_en),
        .ghr_clear_o  (ghr_clear)
    );

    // only the three control-transfer opcodes may redirect fetch
    assign is_branch = (op_i == OPCODE_BRANCH);
    assign is_jump   = (op_i == OPCODE_JAL) || (op_i == OPCODE_JALR);

    // loops close with a branch to a lower address, compared as signed words
    assign is_backward = ($signed(btb_target) < $signed(pc_i));

    // next pc selection
    // a hit on a branch always redirects to the stored target, the taken bit
    // comes from the static backward rule first and the counter second
    always_comb begin
        next_pc_o = pc_i + 32'd4;
        taken_o   = 1'b0;
        if (btb_hit && is_jump) begin
            next_pc_o = btb_target;
            taken_o   = 1'b1;
        end else if (btb_hit && is_branch) begin
            next_pc_o = btb_target;
            if (backward_en && is_backward) begin
                taken_o = 1'b1;
            end else if (dynamic_en) begin
                taken_o = pht_taken;
            end
        end
    end

endmodule

/* testbench/tb_branch_predictor.sv */
`timescale 1ns/100ps

// testbench for the fetch-stage branch predictor
// a reference model of the BTB, the counter table, the GHR and the enables is
// advanced once per cycle at the falling edge, right after the outputs are compared
module tb_branch_predictor
    import bp_isa_pkg::*;
    import bp_config_pkg::*;
();

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int NUM_GHR_BITS    = 5;
    localparam int IDX_W           = $clog2(NUM_BTB_ENTRIES);
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 64;
    localparam int N_RANDOM        = 400;
    // twice the whole stimulus length including the few drain cycles
    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM + 4);
    // an ordinary alu opcode that never redirects fetch
    localparam logic [OPCODE_W-1:0] OPCODE_OPIMM = 7'b0010011;

    logic clk;
    logic reset_i;
    logic [XLEN-1:0] pc_i, upd_pc_i, upd_target_i, cfg_wdata_i;
    logic [OPCODE_W-1:0] op_i;
    logic btb_we_i, pht_we_i, pht_taken_i, cfg_we_i;
    logic [NUM_GHR_BITS-1:0] pht_windex_i;
    logic [CFG_ADDR_W-1:0] cfg_addr_i;
    logic [XLEN-1:0] next_pc_o, cfg_rdata_o;
    logic taken_o;
    logic [NUM_GHR_BITS-1:0] pht_index_o;

    // the reference btb keeps the whole written pc and compares its upper bits
    logic            ref_valid  [NUM_BTB_ENTRIES];
    logic [XLEN-1:0] ref_pc     [NUM_BTB_ENTRIES];
    logic [XLEN-1:0] ref_target [NUM_BTB_ENTRIES];
    int              ref_pht    [1 << NUM_GHR_BITS];
    logic [NUM_GHR_BITS-1:0] ref_ghr;
    logic ref_dyn, ref_bwd, ref_clear;

    logic [32:0] exp_pred;
    logic [31:0] lcg_state;
    int model_errors  = 0;
    int direct_errors = 0;
    int cycle_count   = 0;

    branch_predictor #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES),
        .NUM_GHR_BITS   (NUM_GHR_BITS)
    ) UUT (
        .clk(clk), .reset_i(reset_i), .pc_i(pc_i), .op_i(op_i),
        .btb_we_i(btb_we_i), .upd_pc_i(upd_pc_i), .upd_target_i(upd_target_i),
        .pht_we_i(pht_we_i), .pht_windex_i(pht_windex_i), .pht_taken_i(pht_taken_i),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
        .next_pc_o(next_pc_o), .taken_o(taken_o), .pht_index_o(pht_index_o),
        .cfg_rdata_o(cfg_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 32-bit linear congruential generator
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // history hashed with the word number of the pc, taken modulo the table size
    function automatic logic [NUM_GHR_BITS-1:0] expected_index(input logic [XLEN-1:0] pc);
        return ref_ghr ^ NUM_GHR_BITS'((pc >> 2) % (1 << NUM_GHR_BITS));
    endfunction

    // applies the prediction rule to the model and returns {taken, next pc}
    function automatic logic [32:0] predict(input logic [XLEN-1:0] pc,
                                            input logic [OPCODE_W-1:0] op);
        int unsigned slot;
        logic hit;
        logic dir;
        logic [XLEN-1:0] tgt;
        slot = (pc >> 2) % NUM_BTB_ENTRIES;
        hit  = ref_valid[slot] && ((ref_pc[slot] >> (IDX_W + 2)) == (pc >> (IDX_W + 2)));
        tgt  = ref_target[slot];
        if (!hit || !(op == OPCODE_BRANCH || op == OPCODE_JAL || op == OPCODE_JALR)) begin
            return {1'b0, pc + 32'd4};
        end
        if (op != OPCODE_BRANCH) begin
            return {1'b1, tgt};
        end
        if (ref_bwd && ($signed(tgt) < $signed(pc))) begin
            dir = 1'b1;
        end else if (ref_dyn) begin
            // counter values 2 and 3 predict taken
            dir = (ref_pht[expected_index(pc)] >= 2);
        end else begin
            dir = 1'b0;
        end
        return {dir, tgt};
    endfunction

    task automatic reset_model();
        for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << NUM_GHR_BITS); i++) begin
            ref_pht[i] = int'(CNT_WEAK_NT);
        end
        ref_ghr   = '0;
        ref_dyn   = 1'b1;
        ref_bwd   = 1'b1;
        ref_clear = 1'b0;
    endtask

    // moves the model across the next rising edge with the inputs now applied
    task automatic advance_model();
        int unsigned slot;
        logic clear_next;
        clear_next = cfg_we_i && (cfg_addr_i == CFG_ADDR_HIST) && cfg_wdata_i[0] && !ref_clear;
        if (btb_we_i) begin
            slot = (upd_pc_i >> 2) % NUM_BTB_ENTRIES;
            ref_valid[slot]  = 1'b1;
            ref_pc[slot]     = upd_pc_i;
            ref_target[slot] = upd_target_i;
        end
        // a pending clear pulse beats the outcome shift
        if (ref_clear) begin
            ref_ghr = '0;
        end else if (pht_we_i) begin
            ref_ghr = {ref_ghr[NUM_GHR_BITS-2:0], pht_taken_i};
        end
        if (pht_we_i && pht_taken_i && ref_pht[pht_windex_i] < 3) begin
            ref_pht[pht_windex_i]++;
        end else if (pht_we_i && !pht_taken_i && ref_pht[pht_windex_i] > 0) begin
            ref_pht[pht_windex_i]--;
        end
        if (cfg_we_i && cfg_addr_i == CFG_ADDR_CTRL) begin
            ref_dyn = cfg_wdata_i[0];
            ref_bwd = cfg_wdata_i[1];
        end
        ref_clear = clear_next;
    endtask

    // outputs are compared at the falling edge, half a cycle away from any input change
    always @(negedge clk) begin
        if (reset_i) begin
            reset_model();
        end else begin
            exp_pred = predict(pc_i, op_i);
            assert (next_pc_o === exp_pred[31:0]) else begin
                $display("FAILED next_pc_o: got %h, expected %h", next_pc_o, exp_pred[31:0]);
                model_errors++;
            end
            assert (taken_o === exp_pred[32]) else begin
                $display("FAILED taken_o: got %h, expected %h", taken_o, exp_pred[32]);
                model_errors++;
            end
            assert (pht_index_o === expected_index(pc_i)) else begin
                $display("FAILED pht_index_o: got %h, expected %h", pht_index_o,
                         expected_index(pc_i));
                model_errors++;
            end
            assert (cfg_rdata_o === {30'b0, ref_bwd, ref_dyn}) else begin
                $display("FAILED cfg_rdata_o: got %h, expected %h", cfg_rdata_o,
                         {30'b0, ref_bwd, ref_dyn});
                model_errors++;
            end
            advance_model();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // every drive starts at a rising edge and drops the strobes of the cycle before
    task automatic step();
        @(posedge clk);
        btb_we_i <= 1'b0;
        pht_we_i <= 1'b0;
        cfg_we_i <= 1'b0;
    endtask

    task automatic lookup(input logic [XLEN-1:0] pc, input logic [OPCODE_W-1:0] op);
        step();
        pc_i <= pc;
        op_i <= op;
    endtask

    // the strobe tasks hold their strobe for exactly one cycle
    task automatic write_btb(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target);
        step();
        btb_we_i     <= 1'b1;
        upd_pc_i     <= pc;
        upd_target_i <= target;
        step();
    endtask

    task automatic train(input logic [NUM_GHR_BITS-1:0] windex, input logic taken);
        step();
        pht_we_i     <= 1'b1;
        pht_windex_i <= windex;
        pht_taken_i  <= taken;
        step();
    endtask

    task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
        step();
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        step();
    endtask

    // the clear pulse needs one more edge before the GHR reads zero
    task automatic clear_history();
        write_cfg(CFG_ADDR_HIST, 32'h1);
        step();
    endtask

    task automatic check_pred(input logic [XLEN-1:0] exp_next, input logic exp_taken);
        @(negedge clk);
        assert (next_pc_o === exp_next && taken_o === exp_taken) else begin
            $display("FAILED next_pc_o/taken_o: got %h/%h, expected %h/%h",
                     next_pc_o, taken_o, exp_next, exp_taken);
            direct_errors++;
        end
    endtask

    task automatic check_index(input logic [NUM_GHR_BITS-1:0] exp_index);
        @(negedge clk);
        assert (pht_index_o === exp_index) else begin
            $display("FAILED pht_index_o: got %h, expected %h", pht_index_o, exp_index);
            direct_errors++;
        end
    endtask

    task automatic random_cycle();
        logic [31:0] r1, r2, r3;
        r1 = lcg_next();
        r2 = lcg_next();
        r3 = lcg_next();
        step();
        // a small pc pool, with the sign bit mixed in, so entries hit and alias often
        pc_i         <= {r1[31], 21'b0, r1[9:2], 2'b00};
        op_i         <= (r1[12:11] == 2'd0) ? OPCODE_BRANCH :
                        (r1[12:11] == 2'd1) ? OPCODE_JAL :
                        (r1[12:11] == 2'd2) ? OPCODE_JALR : OPCODE_OPIMM;
        btb_we_i     <= r1[13] & r1[14];
        upd_pc_i     <= {r2[31], 21'b0, r2[9:2], 2'b00};
        upd_target_i <= {r3[31:2], 2'b00};
        pht_we_i     <= r1[15];
        pht_windex_i <= r2[14:10];
        pht_taken_i  <= r2[15];
        cfg_we_i     <= (r1[19:16] == 4'd0);
        cfg_addr_i   <= r1[20];
        cfg_wdata_i  <= r2;
    endtask

    initial begin
        lcg_state    = 32'hfbf5c05b;
        reset_i      = 1'b1;
        pc_i         = '0;
        op_i         = OPCODE_OPIMM;
        btb_we_i     = 1'b0;
        upd_pc_i     = '0;
        upd_target_i = '0;
        pht_we_i     = 1'b0;
        pht_windex_i = '0;
        pht_taken_i  = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = '0;
        cfg_wdata_i  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        // with an empty BTB every lookup falls through and the index is the bare pc bits
        lookup(32'h0000_0054, OPCODE_BRANCH);
        check_pred(32'h0000_0058, 1'b0);
        check_index(5'h15);
        lookup(32'h0000_0200, OPCODE_JAL);
        check_pred(32'h0000_0204, 1'b0);

        // hit after a write, and a miss for the same index with another tag
        write_btb(32'h0000_0100, 32'h0000_0200);
        lookup(32'h0000_0100, OPCODE_JAL);
        check_pred(32'h0000_0200, 1'b1);
        lookup(32'h0000_0180, OPCODE_JAL);
        check_pred(32'h0000_0184, 1'b0);
        lookup(32'h0000_0100, OPCODE_JALR);
        check_pred(32'h0000_0200, 1'b1);

        // backward branch taken by the static rule
        write_btb(32'h0000_0404, 32'h0000_0380);
        lookup(32'h0000_0404, OPCODE_BRANCH);
        check_pred(32'h0000_0380, 1'b1);

        // the forward branch has zero pc index bits so the index equals the GHR
        lookup(32'h0000_0100, OPCODE_BRANCH);
        check_pred(32'h0000_0200, 1'b0);
        train(5'd3, 1'b1);
        check_pred(32'h0000_0200, 1'b0);
        train(5'd3, 1'b1);
        check_pred(32'h0000_0200, 1'b1);
        repeat (3) train(5'd3, 1'b1);
        check_index(5'h1f);
        clear_history();
        check_index(5'h00);

        // pc 0x10c hashes to counter 3, which stays taken after one not-taken step
        write_btb(32'h0000_010c, 32'h0000_0300);
        lookup(32'h0000_010c, OPCODE_BRANCH);
        check_pred(32'h0000_0300, 1'b1);
        train(5'd3, 1'b0);
        check_pred(32'h0000_0300, 1'b1);

        // with the counters off the forward branch falls back to not taken
        write_cfg(CFG_ADDR_CTRL, 32'h2);
        check_pred(32'h0000_0300, 1'b0);
        lookup(32'h0000_0404, OPCODE_BRANCH);
        check_pred(32'h0000_0380, 1'b1);
        // with the static rule off the backward branch follows counter 1 and then counter 0
        write_cfg(CFG_ADDR_CTRL, 32'h1);
        check_pred(32'h0000_0380, 1'b0);
        train(5'd0, 1'b1);
        check_pred(32'h0000_0380, 1'b1);
        write_cfg(CFG_ADDR_CTRL, 32'h3);

        for (int i = 0; i < N_RANDOM; i++) begin
            random_cycle();
        end
        repeat (3) step();

        $display("errors: %0d model mismatches, %0d directed check failures",
                 model_errors, direct_errors);
        if (model_errors == 0 && direct_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/bp_isa_pkg.sv
rtl/bp_config_pkg.sv
rtl/branch_target_buffer.sv
rtl/gshare_predictor.sv
rtl/predictor_control_regs.sv
rtl/branch_predictor.sv
testbench/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

sources:
  - rtl/bp_isa_pkg.sv
  - rtl/bp_config_pkg.sv
  - rtl/branch_target_buffer.sv
  - rtl/gshare_predictor.sv
  - rtl/predictor_control_regs.sv
  - rtl/branch_predictor.sv
  - target: simulation
    files:
      - testbench/tb_branch_predictor.sv
